// ==== rtl/QuadAssembler.sv ====
`timescale 1ns/1ns

module QuadAssembler #(
    parameter int  EXPANDED_SUB_PIXEL_WIDTH = 8,
    localparam int EXPANDED_PIXEL_WIDTH = EXPANDED_SUB_PIXEL_WIDTH * TexturePkg::NUM_SUB_PIXELS
)
(
    input  logic                            aclk,
    input  TexturePkg::quadSelT             quadSel,
    input  TexturePkg::subCoordT            subCoordIn,
    input  TexturePkg::texelT               even0,
    input  TexturePkg::texelT               odd0,
    input  TexturePkg::texelT               even1,
    input  TexturePkg::texelT               odd1,
    output logic [EXPANDED_PIXEL_WIDTH-1:0] texel00,
    output logic [EXPANDED_PIXEL_WIDTH-1:0] texel01,
    output logic [EXPANDED_PIXEL_WIDTH-1:0] texel10,
    output logic [EXPANDED_PIXEL_WIDTH-1:0] texel11,
    output TexturePkg::subCoordT            subCoord
);

    localparam int SW  = TexturePkg::SUB_PIXEL_WIDTH;
    localparam int ESW = EXPANDED_SUB_PIXEL_WIDTH;

    TexturePkg::texelT sel00;
    TexturePkg::texelT sel01;
    TexturePkg::texelT sel10;
    TexturePkg::texelT sel11;
    TexturePkg::texelT quad01;
    TexturePkg::texelT quad10;
    TexturePkg::texelT quad11;

    // Widen each channel, the low bits repeat the channel's top bits
    function automatic logic [EXPANDED_PIXEL_WIDTH-1:0] expand(input TexturePkg::texelT texel);
        logic [EXPANDED_PIXEL_WIDTH-1:0] wide;
        logic [2*SW-1:0]                 twice;
        for (int i = 0; i < TexturePkg::NUM_SUB_PIXELS; i++)
        begin
            twice = {2{texel[i*SW +: SW]}};
            wide[i*ESW +: ESW] = twice[2*SW-1 -: ESW];
        end
        return wide;
    endfunction

    ////////////////////////////////////////
    // Bank select and clamp
    ////////////////////////////////////////

    // Row 0 comes from port B of both banks, row 1 from port A
    assign sel00 = quadSel.addr00[0] ? odd0 : even0;
    assign sel01 = quadSel.addr01[0] ? odd0 : even0;
    assign sel10 = quadSel.addr10[0] ? odd1 : even1;
    assign sel11 = quadSel.addr11[0] ? odd1 : even1;

    assign quad01 = quadSel.clampS ? sel00 : sel01;
    assign quad10 = quadSel.clampT ? sel00 : sel10;

    always_comb
    begin
        if (quadSel.clampS)
        begin
            quad11 = quad10; // Already clamped in t
        end
        else if (quadSel.clampT)
        begin
            quad11 = sel01;
        end
        else
        begin
            quad11 = sel11;
        end
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        texel00  <= expand(sel00);
        texel01  <= expand(quad01);
        texel10  <= expand(quad10);
        texel11  <= expand(quad11);
        subCoord <= subCoordIn; // Keeps step with the texels
    end

endmodule

// ==== rtl/TexelAddressGen.sv ====
`timescale 1ns/1ns

module TexelAddressGen #(
    parameter int  SIZE = 14,
    localparam int ADDR_WIDTH = SIZE - 2
)
(
    input  logic                  aclk,
    input  TexturePkg::texSizeT   texSize,
    input  TexturePkg::texCoordT  coord,
    output logic [ADDR_WIDTH-1:0] evenAddr0,
    output logic [ADDR_WIDTH-1:0] oddAddr0,
    output logic [ADDR_WIDTH-1:0] evenAddr1,
    output logic [ADDR_WIDTH-1:0] oddAddr1,
    output TexturePkg::quadSelT   quadSel,
    output TexturePkg::subCoordT  subCoord
);

    localparam int CW = TexturePkg::COORD_WIDTH;

    logic [3:0]    widthS;
    logic [7:0]    s0;
    logic [7:0]    s1;
    logic [7:0]    t0;
    logic [7:0]    t1;
    logic [CW-1:0] fracS;
    logic [CW-1:0] fracT;
    logic          clampS;
    logic          clampT;
    logic [15:0]   addr00;
    logic [15:0]   addr01;
    logic [15:0]   addr10;
    logic [15:0]   addr11;

    // Number of index bits of one axis
    function automatic logic [3:0] indexWidth(input logic [7:0] code);
        case (code)
            8'b0000_0001: return 4'd1;
            8'b0000_0010: return 4'd2;
            8'b0000_0100: return 4'd3;
            8'b0000_1000: return 4'd4;
            8'b0001_0000: return 4'd5;
            8'b0010_0000: return 4'd6;
            8'b0100_0000: return 4'd7;
            8'b1000_0000: return 4'd8;
            default:      return 4'd0; // Single texel
        endcase
    endfunction

    // Index of the coordinate and its neighbor plus the fraction and the edge clamp
    function automatic void decodeAxis(
        input  logic [7:0]    code,
        input  logic [CW-1:0] pos,
        input  logic          clampIn,
        output logic [7:0]    idx0,
        output logic [7:0]    idx1,
        output logic [CW-1:0] frac,
        output logic          clamp
    );
        logic [3:0]    w;
        int            shift;
        logic [CW-1:0] next;
        logic [CW-1:0] mask;
        w     = indexWidth(code);
        shift = CW - 1 - int'(w);
        next  = pos + (CW'(1) << shift); // One texel step
        mask  = (CW'(1) << w) - CW'(1);
        idx0  = 8'((pos >> shift) & mask);
        idx1  = 8'((next >> shift) & mask);
        frac  = pos << (w + 4'd1);
        // Neighbor wrapped past the edge through the integer bit or out of range
        clamp = clampIn && ((pos > next) || (!pos[CW-1] && next[CW-1]));
    endfunction

    ////////////////////////////////////////
    // Quad addresses
    ////////////////////////////////////////

    always_comb
    begin
        widthS = indexWidth(texSize.width);
        decodeAxis(texSize.width, coord.s, coord.clampS, s0, s1, fracS, clampS);
        decodeAxis(texSize.height, coord.t, coord.clampT, t0, t1, fracT, clampT);

        // t index sits above the s index
        addr00 = ({8'h00, t0} << widthS) | {8'h00, s0};
        addr01 = ({8'h00, t0} << widthS) | {8'h00, s1};
        addr10 = ({8'h00, t1} << widthS) | {8'h00, s0};
        addr11 = ({8'h00, t1} << widthS) | {8'h00, s1};
    end

    // Even parity goes to the even bank and the word address drops the parity bit
    assign evenAddr0 = addr00[0] ? addr01[1 +: ADDR_WIDTH] : addr00[1 +: ADDR_WIDTH];
    assign oddAddr0  = addr00[0] ? addr00[1 +: ADDR_WIDTH] : addr01[1 +: ADDR_WIDTH];
    assign evenAddr1 = addr10[0] ? addr11[1 +: ADDR_WIDTH] : addr10[1 +: ADDR_WIDTH];
    assign oddAddr1  = addr10[0] ? addr10[1 +: ADDR_WIDTH] : addr11[1 +: ADDR_WIDTH];

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        quadSel.addr00 <= addr00; // Parity bits select the bank later
        quadSel.addr01 <= addr01;
        quadSel.addr10 <= addr10;
        quadSel.addr11 <= addr11;
        quadSel.clampS <= clampS;
        quadSel.clampT <= clampT;
        subCoord.s     <= fracS;
        subCoord.t     <= fracT;
    end

endmodule

// ==== rtl/TexelBank.sv ====
`timescale 1ns/1ns

module TexelBank #(
    parameter int  SIZE = 14,
    localparam int ADDR_WIDTH = SIZE - 2
)
(
    input  logic                  aclk,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] writeAddr,
    input  TexturePkg::texelT     writeData,
    input  logic [ADDR_WIDTH-1:0] addrA,
    output TexturePkg::texelT     dataA,
    input  logic [ADDR_WIDTH-1:0] addrB,
    output TexturePkg::texelT     dataB
);

    TexturePkg::texelT     mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] portAAddr;

    // Port A follows the stream while it writes
    assign portAAddr = write ? writeAddr : addrA;

    // Port A, write or second-row read
    always_ff @(posedge aclk)
    begin
        if (write)
        begin
            mem[portAAddr] <= writeData;
        end
        else
        begin
            dataA <= mem[portAAddr];
        end
    end

    // Port B, first-row read only
    always_ff @(posedge aclk)
    begin
        dataB <= mem[addrB];
    end

endmodule

// ==== rtl/TextureBuffer.sv ====
`timescale 1ns/1ns

module TextureBuffer #(
    parameter int  SIZE = 14,
    parameter int  EXPANDED_SUB_PIXEL_WIDTH = 8,
    localparam int ADDR_WIDTH = SIZE - 2,
    localparam int EXPANDED_PIXEL_WIDTH = EXPANDED_SUB_PIXEL_WIDTH * TexturePkg::NUM_SUB_PIXELS
)
(
    input  logic                                aclk,
    input  logic                                resetn,

    // Texture load
    input  logic                                tvalid,
    input  logic                                tlast,
    input  logic [TexturePkg::STREAM_WIDTH-1:0] tdata,

    // Quad read, two cycles
    input  TexturePkg::texSizeT                 texSize,
    input  TexturePkg::texCoordT                coord,
    output logic [EXPANDED_PIXEL_WIDTH-1:0]     texel00,
    output logic [EXPANDED_PIXEL_WIDTH-1:0]     texel01,
    output logic [EXPANDED_PIXEL_WIDTH-1:0]     texel10,
    output logic [EXPANDED_PIXEL_WIDTH-1:0]     texel11,
    output TexturePkg::subCoordT                subCoord
);

    logic [ADDR_WIDTH-1:0] writeAddr;
    TexturePkg::texelT     evenTexel;
    TexturePkg::texelT     oddTexel;
    logic [ADDR_WIDTH-1:0] evenAddr0;
    logic [ADDR_WIDTH-1:0] oddAddr0;
    logic [ADDR_WIDTH-1:0] evenAddr1;
    logic [ADDR_WIDTH-1:0] oddAddr1;
    TexturePkg::quadSelT   quadSel;
    TexturePkg::subCoordT  subCoordStage;
    TexturePkg::texelT     even0;
    TexturePkg::texelT     odd0;
    TexturePkg::texelT     even1;
    TexturePkg::texelT     odd1;

    TextureWriter #(.SIZE(SIZE)) writer
    (
        .aclk     (aclk),
        .resetn   (resetn),
        .tvalid   (tvalid),
        .tlast    (tlast),
        .tdata    (tdata),
        .writeAddr(writeAddr),
        .evenTexel(evenTexel),
        .oddTexel (oddTexel)
    );

    TexelAddressGen #(.SIZE(SIZE)) addressGen
    (
        .aclk     (aclk),
        .texSize  (texSize),
        .coord    (coord),
        .evenAddr0(evenAddr0),
        .oddAddr0 (oddAddr0),
        .evenAddr1(evenAddr1),
        .oddAddr1 (oddAddr1),
        .quadSel  (quadSel),
        .subCoord (subCoordStage)
    );

    ////////////////////////////////////////
    // Banks, port A takes the stream while tvalid is high
    ////////////////////////////////////////

    TexelBank #(.SIZE(SIZE)) evenBank
    (
        .aclk     (aclk),
        .write    (tvalid),
        .writeAddr(writeAddr),
        .writeData(evenTexel),
        .addrA    (evenAddr1),
        .dataA    (even1),
        .addrB    (evenAddr0),
        .dataB    (even0)
    );

    TexelBank #(.SIZE(SIZE)) oddBank
    (
        .aclk     (aclk),
        .write    (tvalid),
        .writeAddr(writeAddr),
        .writeData(oddTexel),
        .addrA    (oddAddr1),
        .dataA    (odd1),
        .addrB    (oddAddr0),
        .dataB    (odd0)
    );

    QuadAssembler #(.EXPANDED_SUB_PIXEL_WIDTH(EXPANDED_SUB_PIXEL_WIDTH)) assembler
    (
        .aclk      (aclk),
        .quadSel   (quadSel),
        .subCoordIn(subCoordStage),
        .even0     (even0),
        .odd0      (odd0),
        .even1     (even1),
        .odd1      (odd1),
        .texel00   (texel00),
        .texel01   (texel01),
        .texel10   (texel10),
        .texel11   (texel11),
        .subCoord  (subCoord)
    );

endmodule

// ==== rtl/TexturePkg.sv ====
package TexturePkg;

    localparam int COORD_WIDTH     = 16;
    localparam int SUB_PIXEL_WIDTH = 4;
    localparam int NUM_SUB_PIXELS  = 4;
    localparam int PIXEL_WIDTH     = SUB_PIXEL_WIDTH * NUM_SUB_PIXELS;
    localparam int STREAM_WIDTH    = 32;

    // RGBA4444, red in the top nibble
    typedef logic [PIXEL_WIDTH-1:0] texelT;

    // One-hot size code per axis, bit n means 2^(n+1) texels, zero means one texel
    typedef struct packed
    {
        logic [7:0] width;
        logic [7:0] height;
    } texSizeT;

    typedef struct packed
    {
        logic [COORD_WIDTH-1:0] s;  // Q1.15
        logic [COORD_WIDTH-1:0] t;  // Q1.15
        logic                   clampS;
        logic                   clampT;
    } texCoordT;

    // Position inside the texel quad
    typedef struct packed
    {
        logic [COORD_WIDTH-1:0] s;  // Q0.16
        logic [COORD_WIDTH-1:0] t;  // Q0.16
    } subCoordT;

    // Texel address is {t index, s index}, bit 0 picks the bank
    typedef struct packed
    {
        logic [15:0] addr00;
        logic [15:0] addr01;
        logic [15:0] addr10;
        logic [15:0] addr11;
        logic        clampS;
        logic        clampT;
    } quadSelT;

endpackage

// ==== rtl/TextureWriter.sv ====
`timescale 1ns/1ns

module TextureWriter #(
    parameter int  SIZE = 14,
    localparam int ADDR_WIDTH = SIZE - 2
)
(
    input  logic                                aclk,
    input  logic                                resetn,
    input  logic                                tvalid,
    input  logic                                tlast,
    input  logic [TexturePkg::STREAM_WIDTH-1:0] tdata,
    output logic [ADDR_WIDTH-1:0]               writeAddr,
    output TexturePkg::texelT                   evenTexel,
    output TexturePkg::texelT                   oddTexel
);

    // One bank word per stream word and a restart after tlast
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeAddr <= '0;
        end
        else if (tvalid)
        begin
            if (tlast)
            begin
                writeAddr <= '0;
            end
            else
            begin
                writeAddr <= writeAddr + ADDR_WIDTH'(1);
            end
        end
    end

    // Low half holds the even-s texel and the high half the odd one
    assign evenTexel = tdata[0 +: TexturePkg::PIXEL_WIDTH];
    assign oddTexel  = tdata[TexturePkg::PIXEL_WIDTH +: TexturePkg::PIXEL_WIDTH];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the texture buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module TextureBufferTb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VTextureBufferTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: fail"
exit 1

// ==== sources.f ====
+incdir+include
rtl/TexturePkg.sv
rtl/TextureWriter.sv
rtl/TexelAddressGen.sv
rtl/TexelBank.sv
rtl/QuadAssembler.sv
rtl/TextureBuffer.sv
testbench/TextureBufferTb.sv

// ==== include/TextureTbUtil.svh ====
`ifndef TEXTURE_TB_UTIL_SVH
`define TEXTURE_TB_UTIL_SVH

localparam int TB_TEXELS = 256; // 16x16 texture

// 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
function automatic logic [31:0] lfsrStep(input logic [31:0] state, input int bits);
    logic [31:0] next;
    next = state;
    for (int i = 0; i < bits; i++)
    begin
        next = {next[30:0], next[31] ^ next[21] ^ next[1] ^ next[0]};
    end
    return next;
endfunction

// Index bits of one axis where anything not one-hot is a single texel
function automatic int refWidth(input logic [7:0] code);
    int w;
    w = 0;
    for (int n = 0; n < 8; n++)
    begin
        if (code == 8'(1 << n))
        begin
            w = n + 1;
        end
    end
    return w;
endfunction

// Channel c widens to the top expWidth bits of {c, c}
function automatic logic [31:0] refExpand(input TexturePkg::texelT texel, input int expWidth);
    logic [31:0] wide;
    logic [7:0]  chan;
    wide = '0;
    for (int i = 0; i < 4; i++)
    begin
        chan = {2{texel[i*4 +: 4]}};
        chan = chan >> (8 - expWidth);
        wide = wide | (32'(chan) << (i * expWidth));
    end
    return wide;
endfunction

// Expected quad and fractions for one read
function automatic void refQuad(
    input  TexturePkg::texelT    tex [TB_TEXELS],
    input  TexturePkg::texSizeT  size,
    input  TexturePkg::texCoordT coord,
    input  int                   expWidth,
    output logic [31:0]          e00,
    output logic [31:0]          e01,
    output logic [31:0]          e10,
    output logic [31:0]          e11,
    output TexturePkg::subCoordT sub
);
    int                ws;
    int                wt;
    int                s0;
    int                s1;
    int                t0;
    int                t1;
    bit                cs;
    bit                ct;
    TexturePkg::texelT q00;
    TexturePkg::texelT q01;
    TexturePkg::texelT q10;
    TexturePkg::texelT q11;
    ws = refWidth(size.width);
    wt = refWidth(size.height);
    s0 = (int'(coord.s) >> (15 - ws)) % (1 << ws);
    t0 = (int'(coord.t) >> (15 - wt)) % (1 << wt);
    s1 = (s0 + 1) % (1 << ws);
    t1 = (t0 + 1) % (1 << wt);
    cs = coord.clampS && (s0 == (1 << ws) - 1); // Last column wraps
    ct = coord.clampT && (t0 == (1 << wt) - 1);
    sub.s = 16'(int'(coord.s) << (ws + 1));
    sub.t = 16'(int'(coord.t) << (wt + 1));
    q00 = tex[((t0 << ws) + s0) % TB_TEXELS];
    q01 = tex[((t0 << ws) + s1) % TB_TEXELS];
    q10 = tex[((t1 << ws) + s0) % TB_TEXELS];
    q11 = tex[((t1 << ws) + s1) % TB_TEXELS];
    if (ct)
    begin
        q10 = q00;
    end
    if (cs)
    begin
        q11 = q10;
    end
    else if (ct)
    begin
        q11 = q01;
    end
    if (cs)
    begin
        q01 = q00;
    end
    e00 = refExpand(q00, expWidth);
    e01 = refExpand(q01, expWidth);
    e10 = refExpand(q10, expWidth);
    e11 = refExpand(q11, expWidth);
endfunction

`endif

// ==== testbench/TextureBufferTb.sv ====
`timescale 1ns/1ns

module TextureBufferTb;

    `include "TextureTbUtil.svh"

    localparam int CLK_PERIOD = 10;
    localparam int EXP_WIDTH  = 8;
    localparam int WORDS      = TB_TEXELS / 2; // Two texels per stream word

    typedef struct packed
    {
        TexturePkg::texSizeT  size;
        TexturePkg::texCoordT coord;
    } stimT;

    logic                 aclk;
    logic                 resetn;
    logic                 tvalid;
    logic                 tlast;
    logic [31:0]          tdata;
    TexturePkg::texSizeT  texSize;
    TexturePkg::texCoordT coord;
    logic [31:0]          texel00;
    logic [31:0]          texel01;
    logic [31:0]          texel10;
    logic [31:0]          texel11;
    TexturePkg::subCoordT subCoord;

    TexturePkg::texelT    texture [TB_TEXELS]; // Copy of the loaded texture
    logic [31:0]          lfsr;
    stimT                 stimulus [$];

    TextureBuffer #(.SIZE(14), .EXPANDED_SUB_PIXEL_WIDTH(EXP_WIDTH)) dut0
    (
        .aclk    (aclk),
        .resetn  (resetn),
        .tvalid  (tvalid),
        .tlast   (tlast),
        .tdata   (tdata),
        .texSize (texSize),
        .coord   (coord),
        .texel00 (texel00),
        .texel01 (texel01),
        .texel10 (texel10),
        .texel11 (texel11),
        .subCoord(subCoord)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compareValue(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected)
        begin
            failRun($sformatf("ERR %0t: %s got %h expected %h", $time, what, actual, expected));
        end
    endtask

    // Counts falling edges and gives up if the clock falls behind
    task automatic waitFalling(input int count);
        int  seen;
        time start;
        seen  = 0;
        start = $time;
        while (seen < count)
        begin
            @(negedge aclk);
            seen++;
            if ($time - start > 64'((count + 1) * CLK_PERIOD))
            begin
                failRun("Timeout while waiting for falling clock edges");
            end
        end
    endtask

    function automatic stimT makeEntry(
        input logic [7:0]  width,
        input logic [7:0]  height,
        input logic [15:0] s,
        input logic [15:0] t,
        input logic        clampS,
        input logic        clampT
    );
        stimT e;
        e.size.width   = width;
        e.size.height  = height;
        e.coord.s      = s;
        e.coord.t      = t;
        e.coord.clampS = clampS;
        e.coord.clampT = clampT;
        return e;
    endfunction

    task automatic buildTable();
        // Every word at 16x16 with its even texel in texel00 and its odd one in texel01
        for (int k = 0; k < WORDS; k++)
        begin
            stimulus.push_back(makeEntry(8'h08, 8'h08, 16'((2 * (k % 8)) << 11),
                                         16'((k / 8) << 11), 1'b0, 1'b0));
        end
        // Whole texels of a 16x16 texture with zero fractions
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h0000, 16'h0000, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h0800, 16'h0000, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h3800, 16'h2000, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h5000, 16'h6800, 1'b0, 1'b0));
        // Mid-texel
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h1A40, 16'h2C10, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h0123, 16'h4567, 1'b0, 1'b0));
        // Wrap at the last column and row
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7C00, 16'h3000, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h2400, 16'h7A00, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7F00, 16'h7F00, 1'b0, 1'b0));
        // Clamp cases where the last two use the integer bit
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7C00, 16'h3000, 1'b1, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h2400, 16'h7A00, 1'b0, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7F00, 16'h7F00, 1'b1, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7F00, 16'h7F00, 1'b1, 1'b0));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h7F00, 16'h7F00, 1'b0, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'hFC00, 16'hF800, 1'b1, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h08, 16'h8800, 16'h9000, 1'b1, 1'b1));
        // Sizes 1x1, 2x2 and 16x4
        stimulus.push_back(makeEntry(8'h00, 8'h00, 16'h4321, 16'h1234, 1'b0, 1'b0));
        stimulus.push_back(makeEntry(8'h00, 8'h00, 16'h4321, 16'h1234, 1'b1, 1'b1));
        stimulus.push_back(makeEntry(8'h01, 8'h01, 16'h6000, 16'h2000, 1'b1, 1'b0));
        stimulus.push_back(makeEntry(8'h01, 8'h01, 16'h4000, 16'h7000, 1'b0, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h02, 16'h5500, 16'h7100, 1'b0, 1'b1));
        stimulus.push_back(makeEntry(8'h08, 8'h02, 16'h7A00, 16'h1F00, 1'b1, 1'b0));
    endtask

    // One word per falling edge with tlast on the final one
    task automatic loadTexture();
        TexturePkg::texelT evenTexel;
        TexturePkg::texelT oddTexel;
        for (int k = 0; k < WORDS; k++)
        begin
            lfsr             = lfsrStep(lfsr, 16);
            evenTexel        = lfsr[15:0]; // 16 fresh bits
            lfsr             = lfsrStep(lfsr, 16);
            oddTexel         = lfsr[15:0];
            texture[2*k]     = evenTexel;
            texture[2*k + 1] = oddTexel;
            tvalid           = 1'b1;
            tlast            = (k == WORDS - 1);
            tdata            = {oddTexel, evenTexel};
            waitFalling(1);
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
    endtask

    task automatic applyEntry(input stimT e);
        texSize = e.size;
        coord   = e.coord;
    endtask

    task automatic checkEntry(input string label, input stimT e);
        logic [31:0]          e00;
        logic [31:0]          e01;
        logic [31:0]          e10;
        logic [31:0]          e11;
        TexturePkg::subCoordT sub;
        refQuad(texture, e.size, e.coord, EXP_WIDTH, e00, e01, e10, e11, sub);
        compareValue({label, " texel00"}, texel00, e00);
        compareValue({label, " texel01"}, texel01, e01);
        compareValue({label, " texel10"}, texel10, e10);
        compareValue({label, " texel11"}, texel11, e11);
        compareValue({label, " subCoord"}, subCoord, sub);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        aclk    = 1'b0;
        resetn  = 1'b0;
        tvalid  = 1'b0;
        tlast   = 1'b0;
        tdata   = '0;
        texSize = '0;
        coord   = '0;
        lfsr    = 32'hdf6c;
        buildTable();
        waitFalling(8);
        resetn = 1'b1;

        // Second load lands on address 0 only if tlast restarted the counter
        loadTexture();
        loadTexture();

        // One read at a time
        for (int i = 0; i < stimulus.size(); i++)
        begin
            applyEntry(stimulus[i]);
            waitFalling(2);
            checkEntry($sformatf("single %0d", i), stimulus[i]);
        end

        // Back to back reads whose results trail by two cycles
        for (int i = 0; i < stimulus.size() + 2; i++)
        begin
            if (i >= 2)
            begin
                checkEntry($sformatf("pipelined %0d", i - 2), stimulus[i - 2]);
            end
            if (i < stimulus.size())
            begin
                applyEntry(stimulus[i]);
            end
            waitFalling(1);
        end

        $display("Test passed");
        $finish;
    end

endmodule
